// ==== design/i2c_master_pkg.sv ====
// Quarter period counts assume a 10 MHz sda clock and only 7-bit device addresses are supported
package i2c_master_pkg;

   // Bus widths
   localparam int DEV_ADDR_W = 7;
   localparam int BYTE_W     = 8;
   localparam int APB_ADDR_W = 5;

   // sda cycles per quarter SCL period
   localparam int QUARTER_STANDARD = 25;
   localparam int QUARTER_FAST     = 6;
   localparam int QUARTER_FASTPLUS = 3;

   // APB register map
   localparam logic [APB_ADDR_W-1:0] REG_ADDR   = 5'h00;
   localparam logic [APB_ADDR_W-1:0] REG_WDATA  = 5'h04;
   localparam logic [APB_ADDR_W-1:0] REG_CMD    = 5'h08;
   localparam logic [APB_ADDR_W-1:0] REG_STATUS = 5'h0C;
   localparam logic [APB_ADDR_W-1:0] REG_RDATA  = 5'h10;

   typedef struct packed {
      logic [DEV_ADDR_W-1:0] dev_addr;
      logic [BYTE_W-1:0]     reg_addr;
      logic [BYTE_W-1:0]     wdata;
      logic                  is_read;
   } i2c_cmd_t;

   typedef enum logic [1:0] {
      COND_START = 2'd0,
      COND_STOP  = 2'd1,
      COND_BIT   = 2'd2
   } cond_e;

   // Meaning of the sample returned with a finished step
   typedef enum logic [1:0] {
      SLOT_NONE = 2'd0,
      SLOT_ACK  = 2'd1,
      SLOT_DATA = 2'd2
   } slot_e;

   typedef struct packed {
      cond_e cond;
      logic  value;
      slot_e slot;
   } bit_req_t;

   typedef struct packed {
      logic  done;
      logic  sample;
      slot_e slot;
   } bit_evt_t;

   typedef struct packed {
      logic              busy;
      logic              nack;
      logic              done;
      logic [BYTE_W-1:0] rdata;
   } result_t;

endpackage

// ==== design/apb_cmd_decode.sv ====
// APB3 slave without wait states that accepts a new command only while the master is idle
`timescale 1ns/1ps

module apb_cmd_decode
(
   input  logic                                  sda,
   input  logic                                  reset,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [i2c_master_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                           pwdata,
   input  i2c_master_pkg::result_t               result,
   output logic [31:0]                           prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   output i2c_master_pkg::i2c_cmd_t              cmd,
   output logic                                  cmd_valid
);

   logic                                  access;
   logic                                  wr_en;
   logic                                  mapped;
   logic                                  cmd_hit;
   logic [i2c_master_pkg::DEV_ADDR_W-1:0] dev_addr_q;
   logic [i2c_master_pkg::BYTE_W-1:0]     reg_addr_q;
   logic [i2c_master_pkg::BYTE_W-1:0]     wdata_q;

   assign access  = psel && penable;
   assign wr_en   = access && pwrite;
   assign cmd_hit = wr_en && (paddr == i2c_master_pkg::REG_CMD);

   always_comb
   begin
      case (paddr)
         i2c_master_pkg::REG_ADDR,
         i2c_master_pkg::REG_WDATA,
         i2c_master_pkg::REG_CMD,
         i2c_master_pkg::REG_STATUS,
         i2c_master_pkg::REG_RDATA: mapped = 1'b1;
         default:                   mapped = 1'b0;
      endcase
   end

   // Zero wait states
   assign pready = 1'b1;

   // Unmapped offset or a command while a transfer is running
   assign pslverr = access && (!mapped || (cmd_hit && result.busy));

   // Launch straight from the access phase so busy is up before the next access
   assign cmd_valid = cmd_hit && !result.busy;

   always_comb
   begin
      cmd.dev_addr = dev_addr_q;
      cmd.reg_addr = reg_addr_q;
      cmd.wdata    = wdata_q;
      cmd.is_read  = pwdata[0];
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         dev_addr_q <= '0;
         reg_addr_q <= '0;
         wdata_q    <= '0;
      end
      else if (wr_en)
      begin
         if (paddr == i2c_master_pkg::REG_ADDR)
         begin
            dev_addr_q <= pwdata[6:0];
            reg_addr_q <= pwdata[15:8];
         end
         if (paddr == i2c_master_pkg::REG_WDATA)
            wdata_q <= pwdata[7:0];
      end
   end

   // Read mux; bit 7 of the address register reads as zero
   always_comb
   begin
      case (paddr)
         i2c_master_pkg::REG_ADDR:   prdata = 32'({reg_addr_q, 1'b0, dev_addr_q});
         i2c_master_pkg::REG_WDATA:  prdata = 32'(wdata_q);
         i2c_master_pkg::REG_STATUS: prdata = 32'({result.done, result.nack, result.busy});
         i2c_master_pkg::REG_RDATA:  prdata = 32'(result.rdata);
         default:                    prdata = '0;
      endcase
   end

endmodule

// ==== design/i2c_txn_sequencer.sv ====
// Handles one single-byte register write or read at a time and aborts to STOP on a missing ACK
`timescale 1ns/1ps

module i2c_txn_sequencer
(
   input  logic                       sda,
   input  logic                       reset,
   input  i2c_master_pkg::i2c_cmd_t   cmd,
   input  logic                       cmd_valid,
   input  logic                       req_ready,
   input  i2c_master_pkg::bit_evt_t   evt,
   output i2c_master_pkg::bit_req_t   req,
   output logic                       req_valid,
   output logic                       txn_start,
   output logic                       txn_end
);

   typedef enum logic [3:0] {
      S_IDLE, S_START, S_DEV_W, S_ACK_DEV_W, S_REG, S_ACK_REG, S_WDATA, S_ACK_WDATA,
      S_RSTART, S_DEV_R, S_ACK_DEV_R, S_RDATA, S_MNACK, S_STOP
   } state_e;

   state_e                            state;
   state_e                            next_state;
   logic [2:0]                        bit_cnt;
   logic                              issued;
   logic                              step_done;
   logic                              last_bit;
   i2c_master_pkg::i2c_cmd_t          cmd_q;
   logic [i2c_master_pkg::BYTE_W-1:0] tx_byte;

   assign step_done = issued && evt.done;
   assign last_bit  = (bit_cnt == 3'd0);
   assign req_valid = (state != S_IDLE) && !issued;

   // Byte sent by the current state, MSB first
   always_comb
   begin
      case (state)
         S_DEV_W: tx_byte = {cmd_q.dev_addr, 1'b0};
         S_REG:   tx_byte = cmd_q.reg_addr;
         S_WDATA: tx_byte = cmd_q.wdata;
         S_DEV_R: tx_byte = {cmd_q.dev_addr, 1'b1};
         default: tx_byte = '0;
      endcase
   end

   always_comb
   begin
      req.cond  = i2c_master_pkg::COND_BIT;
      req.value = 1'b1;
      req.slot  = i2c_master_pkg::SLOT_NONE;
      case (state)
         S_START, S_RSTART: req.cond = i2c_master_pkg::COND_START;
         S_STOP:            req.cond = i2c_master_pkg::COND_STOP;
         S_ACK_DEV_W, S_ACK_REG, S_ACK_WDATA, S_ACK_DEV_R:
            req.slot = i2c_master_pkg::SLOT_ACK;
         S_RDATA:           req.slot = i2c_master_pkg::SLOT_DATA;
         S_DEV_W, S_REG, S_WDATA, S_DEV_R:
            req.value = tx_byte[bit_cnt];
         default:           req.value = 1'b1;
      endcase
   end

   always_comb
   begin
      case (state)
         S_START:     next_state = S_DEV_W;
         S_DEV_W:     next_state = last_bit ? S_ACK_DEV_W : S_DEV_W;
         S_ACK_DEV_W: next_state = S_REG;
         S_REG:       next_state = last_bit ? S_ACK_REG : S_REG;
         S_ACK_REG:   next_state = cmd_q.is_read ? S_RSTART : S_WDATA;
         S_WDATA:     next_state = last_bit ? S_ACK_WDATA : S_WDATA;
         S_ACK_WDATA: next_state = S_STOP;
         S_RSTART:    next_state = S_DEV_R;
         S_DEV_R:     next_state = last_bit ? S_ACK_DEV_R : S_DEV_R;
         S_ACK_DEV_R: next_state = S_RDATA;
         S_RDATA:     next_state = last_bit ? S_MNACK : S_RDATA;
         S_MNACK:     next_state = S_STOP;
         default:     next_state = S_IDLE;
      endcase
      // Target left the line high in an ACK slot
      if (evt.slot == i2c_master_pkg::SLOT_ACK && evt.sample)
         next_state = S_STOP;
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         state     <= S_IDLE;
         bit_cnt   <= 3'd7;
         issued    <= 1'b0;
         txn_start <= 1'b0;
         txn_end   <= 1'b0;
      end
      else
      begin
         txn_start <= 1'b0;
         txn_end   <= 1'b0;
         if (state == S_IDLE)
         begin
            if (cmd_valid)
            begin
               state     <= S_START;
               txn_start <= 1'b1;
            end
         end
         else if (step_done)
         begin
            issued <= 1'b0;
            state  <= next_state;
            // Counter wraps back to 7 after the last bit
            if (state inside {S_DEV_W, S_REG, S_WDATA, S_DEV_R, S_RDATA})
               bit_cnt <= bit_cnt - 3'd1;
            if (state == S_STOP)
               txn_end <= 1'b1;
         end
         else if (req_valid && req_ready)
            issued <= 1'b1;
      end
   end

   always_ff @(posedge sda)
   begin
      if (state == S_IDLE && cmd_valid)
         cmd_q <= cmd;
   end

endmodule

// ==== design/i2c_bit_engine.sv ====
// Open-drain intents only and no clock stretching; every step takes exactly four quarter periods
`timescale 1ns/1ps

module i2c_bit_engine
#(
   parameter int QUARTER = i2c_master_pkg::QUARTER_FAST
)
(
   input  logic                     sda,
   input  logic                     reset,
   input  i2c_master_pkg::bit_req_t req,
   input  logic                     req_valid,
   input  logic                     data_line,
   output logic                     req_ready,
   output i2c_master_pkg::bit_evt_t evt,
   output logic                     scl_drive_low,
   output logic                     data_drive_low
);

   localparam int                 TIMER_W    = $clog2(QUARTER + 1);
   localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(QUARTER - 1);

   logic                     active;
   logic [1:0]               phase;
   logic [TIMER_W-1:0]       timer;
   logic                     evt_done;
   logic                     sample_q;
   logic                     quarter_end;
   i2c_master_pkg::bit_req_t cur;

   // Line levels {scl_low, data_low} for one quarter of a step
   function automatic logic [1:0] line_levels(input i2c_master_pkg::bit_req_t r,
                                              input logic [1:0]               ph,
                                              input logic                     scl_now);
      logic [1:0] lv;
      lv = 2'b00;
      case (r.cond)
         i2c_master_pkg::COND_START:
         begin
            // Keep SCL where it was, so a repeated START starts from low
            case (ph)
               2'd0:    lv = {scl_now, 1'b0};
               2'd1:    lv = 2'b00;
               2'd2:    lv = 2'b01;
               default: lv = 2'b11;
            endcase
         end
         i2c_master_pkg::COND_STOP:
         begin
            case (ph)
               2'd0:    lv = 2'b11;
               2'd1:    lv = 2'b01;
               default: lv = 2'b00;
            endcase
         end
         default:
         begin
            // SCL high in the middle two quarters, data held throughout
            lv[1] = (ph == 2'd0) || (ph == 2'd3);
            lv[0] = !r.value;
         end
      endcase
      return lv;
   endfunction

   assign req_ready   = !active;
   assign quarter_end = (timer == TIMER_LAST);

   always_comb
   begin
      evt.done   = evt_done;
      evt.sample = sample_q;
      evt.slot   = cur.slot;
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         active         <= 1'b0;
         phase          <= 2'd0;
         timer          <= '0;
         evt_done       <= 1'b0;
         scl_drive_low  <= 1'b0;
         data_drive_low <= 1'b0;
      end
      else
      begin
         evt_done <= 1'b0;
         if (!active)
         begin
            if (req_valid)
            begin
               active <= 1'b1;
               phase  <= 2'd0;
               timer  <= '0;
               {scl_drive_low, data_drive_low} <= line_levels(req, 2'd0, scl_drive_low);
            end
         end
         else if (quarter_end)
         begin
            timer <= '0;
            if (phase == 2'd3)
            begin
               active   <= 1'b0;
               evt_done <= 1'b1;
            end
            else
            begin
               phase <= phase + 2'd1;
               {scl_drive_low, data_drive_low} <=
                  line_levels(cur, phase + 2'd1, scl_drive_low);
            end
         end
         else
            timer <= timer + 1'b1;
      end
   end

   // Step payload and the sample taken at the end of the third quarter
   always_ff @(posedge sda)
   begin
      if (!active && req_valid)
         cur <= req;
      if (active && quarter_end && phase == 2'd2)
         sample_q <= data_line;
   end

endmodule

// ==== design/i2c_result_capture.sv ====
// Status of the most recent transfer only; the received byte is meaningful after a read
`timescale 1ns/1ps

module i2c_result_capture
(
   input  logic                     sda,
   input  logic                     reset,
   input  logic                     txn_start,
   input  logic                     txn_end,
   input  i2c_master_pkg::bit_evt_t evt,
   output i2c_master_pkg::result_t  result
);

   logic data_bit;
   logic ack_missing;

   assign data_bit    = evt.done && (evt.slot == i2c_master_pkg::SLOT_DATA);
   assign ack_missing = evt.done && (evt.slot == i2c_master_pkg::SLOT_ACK) && evt.sample;

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         result.busy <= 1'b0;
         result.nack <= 1'b0;
         result.done <= 1'b0;
      end
      else if (txn_start)
      begin
         result.busy <= 1'b1;
         result.nack <= 1'b0;
         result.done <= 1'b0;
      end
      else
      begin
         if (txn_end)
         begin
            result.busy <= 1'b0;
            result.done <= 1'b1;
         end
         if (ack_missing)
            result.nack <= 1'b1;
      end
   end

   // Read data arrives MSB first
   always_ff @(posedge sda)
   begin
      if (reset)
         result.rdata <= '0;
      else if (data_bit)
         result.rdata <= {result.rdata[i2c_master_pkg::BYTE_W-2:0], evt.sample};
   end

endmodule

// ==== design/i2c_master_top.sv ====
// Pull-ups on both bus lines must be provided outside this block
`timescale 1ns/1ps

module i2c_master_top
#(
   parameter int QUARTER = i2c_master_pkg::QUARTER_FAST
)
(
   input  logic                                  sda,
   input  logic                                  reset,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [i2c_master_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                           pwdata,
   input  logic                                  data_line,
   output logic [31:0]                           prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   output logic                                  scl_drive_low,
   output logic                                  data_drive_low
);

   i2c_master_pkg::i2c_cmd_t cmd;
   logic                     cmd_valid;
   i2c_master_pkg::bit_req_t req;
   logic                     req_valid;
   logic                     req_ready;
   i2c_master_pkg::bit_evt_t evt;
   logic                     txn_start;
   logic                     txn_end;
   i2c_master_pkg::result_t  result;

   apb_cmd_decode u_apb_cmd_decode (
      .sda       (sda),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .result    (result),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .cmd       (cmd),
      .cmd_valid (cmd_valid)
   );

   i2c_txn_sequencer u_i2c_txn_sequencer (
      .sda       (sda),
      .reset     (reset),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .req_ready (req_ready),
      .evt       (evt),
      .req       (req),
      .req_valid (req_valid),
      .txn_start (txn_start),
      .txn_end   (txn_end)
   );

   i2c_bit_engine #(
      .QUARTER (QUARTER)
   ) u_i2c_bit_engine (
      .sda            (sda),
      .reset          (reset),
      .req            (req),
      .req_valid      (req_valid),
      .data_line      (data_line),
      .req_ready      (req_ready),
      .evt            (evt),
      .scl_drive_low  (scl_drive_low),
      .data_drive_low (data_drive_low)
   );

   i2c_result_capture u_i2c_result_capture (
      .sda       (sda),
      .reset     (reset),
      .txn_start (txn_start),
      .txn_end   (txn_end),
      .evt       (evt),
      .result    (result)
   );

endmodule

// ==== verification/i2c_target_model.sv ====
// No clock stretching, one fixed device address, and a register pointer that auto-increments
`timescale 1ns/1ps

module i2c_target_model
#(
   parameter logic [6:0] DEV_ADDR = 7'h50
)
(
   input  logic scl_line,
   input  logic data_line,
   output logic data_drive_low
);

   typedef enum logic [2:0] {
      T_IDLE, T_ADDR, T_REG, T_WDATA, T_RDATA, T_IGNORE
   } tstate_e;

   logic [7:0] mem [0:255];
   tstate_e    state;
   logic [7:0] shift_q;
   logic [7:0] tx_byte;
   logic [7:0] reg_ptr;
   logic       read_mode;
   int         bit_cnt;
   logic       scl_q;
   logic       data_q;

   // Rising SCL takes in a bit or reads the master's ACK after a sent byte
   task automatic scl_rise();
      case (state)
         T_ADDR, T_REG, T_WDATA:
         begin
            if (bit_cnt < 8)
            begin
               shift_q = {shift_q[6:0], data_line};
               bit_cnt++;
            end
         end
         T_RDATA:
         begin
            if (bit_cnt < 8)
               bit_cnt++;
            else if (bit_cnt == 8)
            begin
               // Master NACK ends the read
               if (data_line)
                  state = T_IGNORE;
               else
                  bit_cnt = 9;
            end
         end
         default:
            bit_cnt = bit_cnt;
      endcase
   endtask

   // Falling SCL is the only point where this model changes the data line
   task automatic scl_fall();
      case (state)
         T_ADDR, T_REG, T_WDATA:
         begin
            if (bit_cnt == 8)
            begin
               if (state == T_ADDR && shift_q[7:1] != DEV_ADDR)
                  state = T_IGNORE;
               else
               begin
                  data_drive_low = 1'b1;
                  bit_cnt = 9;
                  if (state == T_ADDR)
                     read_mode = shift_q[0];
                  else if (state == T_REG)
                     reg_ptr = shift_q;
                  else
                  begin
                     mem[reg_ptr] = shift_q;
                     reg_ptr++;
                  end
               end
            end
            else if (bit_cnt == 9)
            begin
               // End of our ACK slot
               data_drive_low = 1'b0;
               bit_cnt = 0;
               if (state == T_ADDR && read_mode)
               begin
                  state = T_RDATA;
                  tx_byte = mem[reg_ptr];
                  data_drive_low = !tx_byte[7];
               end
               else if (state == T_ADDR)
                  state = T_REG;
               else if (state == T_REG)
                  state = T_WDATA;
            end
         end
         T_RDATA:
         begin
            if (bit_cnt < 8)
               data_drive_low = !tx_byte[7 - bit_cnt];
            else if (bit_cnt == 8)
               data_drive_low = 1'b0;
            else
            begin
               // Master acked, so send the next register
               reg_ptr++;
               tx_byte = mem[reg_ptr];
               data_drive_low = !tx_byte[7];
               bit_cnt = 0;
            end
         end
         default:
            data_drive_low = 1'b0;
      endcase
   endtask

   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[i] = 8'(i) ^ 8'hA5;
      state          = T_IDLE;
      shift_q        = 8'h00;
      tx_byte        = 8'h00;
      reg_ptr        = 8'h00;
      read_mode      = 1'b0;
      bit_cnt        = 0;
      scl_q          = 1'b1;
      data_q         = 1'b1;
      data_drive_low = 1'b0;
   end

   always @(scl_line or data_line)
   begin
      if (scl_q === 1'b1 && scl_line === 1'b1 && data_q === 1'b1 && data_line === 1'b0)
      begin
         // START or repeated START
         state          = T_ADDR;
         bit_cnt        = 0;
         data_drive_low = 1'b0;
      end
      else if (scl_q === 1'b1 && scl_line === 1'b1 && data_q === 1'b0 && data_line === 1'b1)
      begin
         state          = T_IDLE;
         data_drive_low = 1'b0;
      end
      else if (scl_q === 1'b0 && scl_line === 1'b1)
         scl_rise();
      else if (scl_q === 1'b1 && scl_line === 1'b0)
         scl_fall();
      scl_q  = scl_line;
      data_q = data_line;
   end

endmodule

// ==== verification/tb_i2c_master.sv ====
// Standard-mode timing against one target at 0x50; every wait gives up after a bounded count
`timescale 1ns/1ps

module tb_i2c_master;

   localparam int         POLL_LIMIT  = 5000;
   localparam int         READY_LIMIT = 16;
   localparam logic [6:0] TARGET_ADDR = 7'h50;
   localparam logic [6:0] ABSENT_ADDR = 7'h23;

   typedef struct packed {
      logic       is_read;
      logic [6:0] dev_addr;
      logic [7:0] reg_addr;
      logic [7:0] wdata;
      logic       exp_nack;
      logic [7:0] exp_rdata;
   } stim_row_t;

   logic        sda;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [4:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        scl_drive_low;
   logic        data_drive_low;
   logic        target_data_low;
   logic        scl_bus;
   logic        data_bus;
   stim_row_t   stim_q[$];
   logic [7:0]  rand_byte [0:2];
   int          seed;

   // Open-drain lines, high unless somebody pulls them low
   assign scl_bus  = !scl_drive_low;
   assign data_bus = !(data_drive_low || target_data_low);

   i2c_master_top #(
      .QUARTER (i2c_master_pkg::QUARTER_STANDARD)
   ) u_i2c_master_top (
      .sda            (sda),
      .reset          (reset),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .data_line      (data_bus),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .scl_drive_low  (scl_drive_low),
      .data_drive_low (data_drive_low)
   );

   i2c_target_model #(
      .DEV_ADDR (TARGET_ADDR)
   ) u_i2c_target_model (
      .scl_line       (scl_bus),
      .data_line      (data_bus),
      .data_drive_low (target_data_low)
   );

   initial
   begin
      sda = 1'b0;
      forever #50 sda = ~sda;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         abort_run($sformatf("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                             $time, name, expected, actual));
   endtask

   // One APB3 transfer, inputs changed 5 ns after the rising edge
   task automatic apb_access(input logic write, input logic [4:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int cycles;
      cycles = 0;
      @(posedge sda);
      #5;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge sda);
      #5;
      penable = 1'b1;
      // Responses are read mid-cycle
      @(negedge sda);
      while (pready !== 1'b1)
      begin
         if (cycles == READY_LIMIT)
            abort_run("APB access never saw pready high");
         cycles++;
         @(negedge sda);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge sda);
      #5;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_write(input logic [4:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] unused;
      logic        err;
      apb_access(1'b1, addr, data, unused, err);
      check_value("pslverr", 32'(err), 32'(exp_err));
   endtask

   task automatic reg_read(input logic [4:0] addr, input logic exp_err,
                           output logic [31:0] data);
      logic err;
      apb_access(1'b0, addr, 32'h0, data, err);
      check_value("pslverr", 32'(err), 32'(exp_err));
   endtask

   task automatic wait_for_done(output logic [31:0] status);
      int polls;
      polls = 0;
      reg_read(i2c_master_pkg::REG_STATUS, 1'b0, status);
      while (status[2] !== 1'b1)
      begin
         if (polls == POLL_LIMIT)
            abort_run("Transfer never reported done in STATUS");
         polls++;
         reg_read(i2c_master_pkg::REG_STATUS, 1'b0, status);
      end
   endtask

   task automatic add_row(input logic is_read, input logic [6:0] dev, input logic [7:0] reg_sel,
                          input logic [7:0] wdata, input logic exp_nack,
                          input logic [7:0] exp_rdata);
      stim_row_t row;
      row.is_read   = is_read;
      row.dev_addr  = dev;
      row.reg_addr  = reg_sel;
      row.wdata     = wdata;
      row.exp_nack  = exp_nack;
      row.exp_rdata = exp_rdata;
      stim_q.push_back(row);
   endtask

   task automatic run_row(input stim_row_t row);
      logic [31:0] status;
      logic [31:0] rdata;
      reg_write(i2c_master_pkg::REG_ADDR, {16'h0, row.reg_addr, 1'b0, row.dev_addr}, 1'b0);
      reg_write(i2c_master_pkg::REG_WDATA, 32'(row.wdata), 1'b0);
      // Address and write byte registers read back what was written
      reg_read(i2c_master_pkg::REG_ADDR, 1'b0, rdata);
      check_value("addr_reg", rdata, {16'h0, row.reg_addr, 1'b0, row.dev_addr});
      reg_read(i2c_master_pkg::REG_WDATA, 1'b0, rdata);
      check_value("wdata_reg", rdata, 32'(row.wdata));
      reg_write(i2c_master_pkg::REG_CMD, 32'(row.is_read), 1'b0);
      // Second command while the first is still running must be refused
      reg_write(i2c_master_pkg::REG_CMD, 32'(row.is_read), 1'b1);
      wait_for_done(status);
      check_value("status", status, {29'h0, 1'b1, row.exp_nack, 1'b0});
      if (row.is_read && !row.exp_nack)
      begin
         reg_read(i2c_master_pkg::REG_RDATA, 1'b0, rdata);
         check_value("rdata", rdata, 32'(row.exp_rdata));
      end
   endtask

   initial
   begin
      int          rnd;
      logic [31:0] status;
      logic [31:0] rdata;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed    = 10;
      rnd     = $urandom(seed);
      for (int i = 0; i < 3; i++)
         rand_byte[i] = 8'($urandom);
      repeat (16) @(posedge sda);
      #5;
      reset = 1'b0;

      @(negedge sda);
      check_value("scl_drive_low", 32'(scl_drive_low), 32'h0);
      check_value("data_drive_low", 32'(data_drive_low), 32'h0);
      check_value("pslverr", 32'(pslverr), 32'h0);
      reg_read(i2c_master_pkg::REG_STATUS, 1'b0, status);
      check_value("status", status, 32'h0);

      // is_read, device, register, write byte, nack, read byte
      add_row(1'b0, TARGET_ADDR, 8'h10, rand_byte[0], 1'b0, 8'h00);
      add_row(1'b1, TARGET_ADDR, 8'h10, 8'h00, 1'b0, rand_byte[0]);
      add_row(1'b0, TARGET_ADDR, 8'h22, rand_byte[1], 1'b0, 8'h00);
      add_row(1'b0, TARGET_ADDR, 8'h7F, rand_byte[2], 1'b0, 8'h00);
      add_row(1'b1, TARGET_ADDR, 8'h22, 8'h00, 1'b0, rand_byte[1]);
      add_row(1'b1, TARGET_ADDR, 8'h7F, 8'h00, 1'b0, rand_byte[2]);
      add_row(1'b0, ABSENT_ADDR, 8'h10, ~rand_byte[0], 1'b1, 8'h00);
      add_row(1'b1, TARGET_ADDR, 8'h10, 8'h00, 1'b0, rand_byte[0]);
      add_row(1'b1, ABSENT_ADDR, 8'h22, 8'h00, 1'b1, 8'h00);
      add_row(1'b0, TARGET_ADDR, 8'h22, ~rand_byte[1], 1'b0, 8'h00);
      add_row(1'b1, TARGET_ADDR, 8'h22, 8'h00, 1'b0, ~rand_byte[1]);

      foreach (stim_q[i])
         run_row(stim_q[i]);

      // Unmapped offsets
      reg_read(5'h14, 1'b1, rdata);
      reg_write(5'h1C, 32'h1, 1'b1);

      $display("All checks passed");
      $finish;
   end

endmodule

// ==== src.f ====
design/i2c_master_pkg.sv
design/apb_cmd_decode.sv
design/i2c_txn_sequencer.sv
design/i2c_bit_engine.sv
design/i2c_result_capture.sv
design/i2c_master_top.sv
verification/i2c_target_model.sv
verification/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - design/i2c_master_pkg.sv
  - design/apb_cmd_decode.sv
  - design/i2c_txn_sequencer.sv
  - design/i2c_bit_engine.sv
  - design/i2c_result_capture.sv
  - design/i2c_master_top.sv
  - target: simulation
    files:
      - verification/i2c_target_model.sv
      - verification/tb_i2c_master.sv

export_include_dirs: []

workspace: {}
